// ==== rtl/limb_defines.svh ====
`ifndef LIMB_DEFINES_SVH
`define LIMB_DEFINES_SVH

// data path widths
`define LIMB_WORD_W       32
`define LIMB_GAIN_W       16

// transmit sck phase length in clock cycles, divider of 13
`define LIMB_SPI_HALF     13

`define LIMB_SYNC_STAGES  2   // input pin synchronizer depth

// host register map
`define LIMB_ADDR_W       8
`define LIMB_GAIN_RESET   1
`define LIMB_REG_GAIN      8'h00
`define LIMB_REG_LAST_RATE 8'h04
`define LIMB_REG_FRAMES    8'h08
`define LIMB_REG_DROPS     8'h0C

`endif

// ==== rtl/limb_host_pkg.sv ====
`include "limb_defines.svh"

package limb_host_pkg;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } resp_e;

    typedef enum logic [`LIMB_ADDR_W-1:0] {
        REG_GAIN      = `LIMB_REG_GAIN,
        REG_LAST_RATE = `LIMB_REG_LAST_RATE,
        REG_FRAMES    = `LIMB_REG_FRAMES,
        REG_DROPS     = `LIMB_REG_DROPS
    } reg_addr_e;

    // master side of the AXI4-Lite link
    typedef struct packed {
        logic                       aw_valid;
        logic [`LIMB_ADDR_W-1:0]    aw_addr;
        logic                       w_valid;
        logic [`LIMB_WORD_W-1:0]    w_data;
        logic [`LIMB_WORD_W/8-1:0]  w_strb;
        logic                       b_ready;
        logic                       ar_valid;
        logic [`LIMB_ADDR_W-1:0]    ar_addr;
        logic                       r_ready;
    } axil_req_t;

    // slave side
    typedef struct packed {
        logic                       aw_ready;
        logic                       w_ready;
        logic                       b_valid;
        resp_e                      b_resp;
        logic                       ar_ready;
        logic                       r_valid;
        logic [`LIMB_WORD_W-1:0]    r_data;
        resp_e                      r_resp;
    } axil_rsp_t;

endpackage

// ==== rtl/limb_link_pkg.sv ====
`include "limb_defines.svh"

package limb_link_pkg;

    // one rate word between stages
    typedef struct packed {
        logic                     valid;
        logic [`LIMB_WORD_W-1:0]  data;
    } rate_word_t;

    // same bundle for input and output links
    typedef struct packed {
        logic sck;
        logic mosi;
        logic ssel_n;   // active low frame select
    } spi_pins_t;

    typedef enum logic [1:0] {
        IDLE,
        SHIFT,
        GAP
    } spi_state_e;

endpackage

// ==== rtl/host_regs.sv ====
`include "limb_defines.svh"

module host_regs (
    input  logic                       i_ep50trig,
    input  logic                       i_reset_global,
    input  limb_host_pkg::axil_req_t   i_axil,
    output limb_host_pkg::axil_rsp_t   o_axil,
    input  logic [`LIMB_WORD_W-1:0]    i_last_rate,
    input  logic [`LIMB_WORD_W-1:0]    i_frames,
    input  logic [`LIMB_WORD_W-1:0]    i_drops,
    output logic [`LIMB_GAIN_W-1:0]    o_gain
);

    localparam int WORD_W     = `LIMB_WORD_W;
    localparam int GAIN_W     = `LIMB_GAIN_W;
    localparam int GAIN_BYTES = GAIN_W / 8;

    logic                        wr_fire;
    logic                        rd_fire;
    logic                        b_valid_q;
    limb_host_pkg::resp_e        b_resp_q;
    logic                        r_valid_q;
    logic [WORD_W-1:0]           r_data_q;
    limb_host_pkg::resp_e        r_resp_q;
    logic [GAIN_W-1:0]           gain_q;
    limb_host_pkg::reg_addr_e    rd_addr;
    logic [WORD_W-1:0]           rd_data;
    limb_host_pkg::resp_e        rd_resp;

    assign wr_fire = i_axil.aw_valid & i_axil.w_valid & ~b_valid_q;
    assign rd_fire = i_axil.ar_valid & ~r_valid_q;

    //////////////////////////////////////////////////////////////////////
    // write channel, gain is the only writable register
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge i_ep50trig or posedge i_reset_global) begin
        if (i_reset_global) begin
            b_valid_q <= 1'b0;
            b_resp_q  <= limb_host_pkg::RESP_OKAY;
            gain_q    <= GAIN_W'(`LIMB_GAIN_RESET);
        end else if (wr_fire) begin
            b_valid_q <= 1'b1;
            if (limb_host_pkg::reg_addr_e'(i_axil.aw_addr) == limb_host_pkg::REG_GAIN) begin
                b_resp_q <= limb_host_pkg::RESP_OKAY;
                for (int b = 0; b < GAIN_BYTES; b++) begin
                    if (i_axil.w_strb[b])
                        gain_q[b*8 +: 8] <= i_axil.w_data[b*8 +: 8];
                end
            end else begin
                b_resp_q <= limb_host_pkg::RESP_SLVERR;  // status regs are read only
            end
        end else if (i_axil.b_ready) begin
            b_valid_q <= 1'b0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read channel
    //////////////////////////////////////////////////////////////////////
    assign rd_addr = limb_host_pkg::reg_addr_e'(i_axil.ar_addr);

    always_comb begin
        rd_resp = limb_host_pkg::RESP_OKAY;
        case (rd_addr)
            limb_host_pkg::REG_GAIN:      rd_data = {{(WORD_W-GAIN_W){1'b0}}, gain_q};
            limb_host_pkg::REG_LAST_RATE: rd_data = i_last_rate;
            limb_host_pkg::REG_FRAMES:    rd_data = i_frames;
            limb_host_pkg::REG_DROPS:     rd_data = i_drops;
            default: begin
                rd_data = '0;  // unmapped
                rd_resp = limb_host_pkg::RESP_SLVERR;
            end
        endcase
    end

    always_ff @(posedge i_ep50trig or posedge i_reset_global) begin
        if (i_reset_global) begin
            r_valid_q <= 1'b0;
            r_resp_q  <= limb_host_pkg::RESP_OKAY;
        end else if (rd_fire) begin
            r_valid_q <= 1'b1;
            r_resp_q  <= rd_resp;
        end else if (i_axil.r_ready) begin
            r_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge i_ep50trig) begin
        if (rd_fire)
            r_data_q <= rd_data;
    end

    always_comb begin
        o_axil.aw_ready = wr_fire;  // aw and w taken together
        o_axil.w_ready  = wr_fire;
        o_axil.b_valid  = b_valid_q;
        o_axil.b_resp   = b_resp_q;
        o_axil.ar_ready = rd_fire;
        o_axil.r_valid  = r_valid_q;
        o_axil.r_data   = r_data_q;
        o_axil.r_resp   = r_resp_q;
    end

    assign o_gain = gain_q;

    // write response must wait for the host
    a_bvalid_hold: assert property (@(posedge i_ep50trig) disable iff (i_reset_global)
        b_valid_q && !i_axil.b_ready |=> b_valid_q);

endmodule

// ==== rtl/spindle_rx.sv ====
`include "limb_defines.svh"

module spindle_rx (
    input  logic                         i_ep50trig,
    input  logic                         i_reset_global,
    input  limb_link_pkg::spi_pins_t     i_pins,
    output limb_link_pkg::rate_word_t    o_word,
    output logic [`LIMB_WORD_W-1:0]      o_last_rate,
    output logic [`LIMB_WORD_W-1:0]      o_frames
);

    localparam int WORD_W = `LIMB_WORD_W;
    localparam int SYNC   = `LIMB_SYNC_STAGES;
    localparam int CNT_W  = $clog2(WORD_W) + 1;  // room to see more than 32 bits
    localparam limb_link_pkg::spi_pins_t PINS_IDLE = '{sck: 1'b0, mosi: 1'b0, ssel_n: 1'b1};

    limb_link_pkg::spi_pins_t sync_q [SYNC];
    limb_link_pkg::spi_pins_t pins_s;
    limb_link_pkg::spi_pins_t pins_d;
    logic                     sck_rise;
    logic                     ssel_rise;
    logic [CNT_W-1:0]         bit_cnt;
    logic [WORD_W-1:0]        shift_q;
    logic                     word_valid;
    logic [WORD_W-1:0]        word_data;

    //////////////////////////////////////////////////////////////////////
    // pin synchronizer and edge detect
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge i_ep50trig or posedge i_reset_global) begin
        if (i_reset_global) begin
            for (int i = 0; i < SYNC; i++)
                sync_q[i] <= PINS_IDLE;
            pins_d <= PINS_IDLE;
        end else begin
            sync_q[0] <= i_pins;
            for (int i = 1; i < SYNC; i++)
                sync_q[i] <= sync_q[i-1];
            pins_d <= pins_s;
        end
    end

    assign pins_s    = sync_q[SYNC-1];
    assign sck_rise  = pins_s.sck & ~pins_d.sck;
    assign ssel_rise = pins_s.ssel_n & ~pins_d.ssel_n;  // end of frame

    always_ff @(posedge i_ep50trig or posedge i_reset_global) begin
        if (i_reset_global) begin
            bit_cnt     <= '0;
            word_valid  <= 1'b0;
            o_last_rate <= '0;
            o_frames    <= '0;
        end else begin
            word_valid <= 1'b0;
            if (ssel_rise && bit_cnt == CNT_W'(WORD_W)) begin
                word_valid  <= 1'b1;
                o_last_rate <= shift_q;
                o_frames    <= o_frames + 1'b1;
            end
            if (pins_s.ssel_n)
                bit_cnt <= '0;
            else if (sck_rise && bit_cnt != '1)
                bit_cnt <= bit_cnt + 1'b1;   // saturates on long frames
        end
    end

    always_ff @(posedge i_ep50trig) begin
        if (!pins_s.ssel_n && sck_rise)
            shift_q <= {shift_q[WORD_W-2:0], pins_s.mosi};  // msb first
        if (ssel_rise)
            word_data <= shift_q;
    end

    assign o_word = '{valid: word_valid, data: word_data};

    a_full_frame: assert property (@(posedge i_ep50trig) disable iff (i_reset_global)
        word_valid |-> $past(ssel_rise) && $past(bit_cnt) == CNT_W'(WORD_W));

endmodule

// ==== rtl/rate_scaler.sv ====
`include "limb_defines.svh"

module rate_scaler (
    input  logic                         i_ep50trig,
    input  logic                         i_reset_global,
    input  limb_link_pkg::rate_word_t    i_word,
    input  logic [`LIMB_GAIN_W-1:0]      i_gain,
    input  logic                         i_ready,
    output limb_link_pkg::rate_word_t    o_word,
    output logic [`LIMB_WORD_W-1:0]      o_drops
);

    localparam int WORD_W = `LIMB_WORD_W;
    localparam int GAIN_W = `LIMB_GAIN_W;

    logic [WORD_W+GAIN_W-1:0] product;
    logic [WORD_W-1:0]        scaled;
    logic                     full_q;
    logic [WORD_W-1:0]        data_q;
    logic                     drain;
    logic                     accept;

    assign product = i_word.data * i_gain;
    assign scaled  = (|product[WORD_W+GAIN_W-1:WORD_W]) ? '1 : product[WORD_W-1:0];

    assign drain  = full_q & i_ready;
    assign accept = i_word.valid & (~full_q | drain);  // slot free or freeing now

    always_ff @(posedge i_ep50trig or posedge i_reset_global) begin
        if (i_reset_global) begin
            full_q  <= 1'b0;
            o_drops <= '0;
        end else begin
            if (accept)
                full_q <= 1'b1;
            else if (drain)
                full_q <= 1'b0;
            if (i_word.valid && !accept)
                o_drops <= o_drops + 1'b1;
        end
    end

    always_ff @(posedge i_ep50trig) begin
        if (accept)
            data_q <= scaled;
    end

    assign o_word = '{valid: full_q, data: data_q};

    a_hold_stalled: assert property (@(posedge i_ep50trig) disable iff (i_reset_global)
        o_word.valid && !i_ready |=> o_word.valid && $stable(o_word.data));

endmodule

// ==== rtl/spi_tx.sv ====
`include "limb_defines.svh"

module spi_tx (
    input  logic                         i_ep50trig,
    input  logic                         i_reset_global,
    input  limb_link_pkg::rate_word_t    i_word,
    output logic                         o_ready,
    output limb_link_pkg::spi_pins_t     o_pins
);

    localparam int WORD_W = `LIMB_WORD_W;
    localparam int HALF   = `LIMB_SPI_HALF;
    localparam int HALF_W = $clog2(HALF);
    localparam int BIT_W  = $clog2(WORD_W);

    limb_link_pkg::spi_state_e state;
    logic [HALF_W-1:0]         half_cnt;
    logic                      half_end;
    logic [BIT_W-1:0]          bit_cnt;
    logic [WORD_W-1:0]         shift_q;
    logic                      sck_q;
    logic                      mosi_q;
    logic                      ssel_n_q;
    logic                      sck_fall;

    assign o_ready  = (state == limb_link_pkg::IDLE);
    assign half_end = (half_cnt == HALF_W'(HALF - 1));
    assign sck_fall = (state == limb_link_pkg::SHIFT) && half_end && sck_q;

    //////////////////////////////////////////////////////////////////////
    // transmit FSM
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge i_ep50trig or posedge i_reset_global) begin
        if (i_reset_global) begin
            state    <= limb_link_pkg::IDLE;
            half_cnt <= '0;
            bit_cnt  <= '0;
            sck_q    <= 1'b0;
            mosi_q   <= 1'b0;
            ssel_n_q <= 1'b1;
        end else begin
            case (state)
                limb_link_pkg::IDLE: begin
                    half_cnt <= '0;
                    bit_cnt  <= '0;
                    if (i_word.valid) begin
                        state    <= limb_link_pkg::SHIFT;
                        ssel_n_q <= 1'b0;
                        mosi_q   <= i_word.data[WORD_W-1];  // first bit ahead of sck
                    end
                end
                limb_link_pkg::SHIFT: begin
                    half_cnt <= half_end ? '0 : half_cnt + 1'b1;
                    if (half_end)
                        sck_q <= ~sck_q;
                    if (sck_fall) begin
                        if (bit_cnt == BIT_W'(WORD_W - 1)) begin
                            state    <= limb_link_pkg::GAP;
                            ssel_n_q <= 1'b1;
                            mosi_q   <= 1'b0;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            mosi_q  <= shift_q[WORD_W-2];  // next bit
                        end
                    end
                end
                limb_link_pkg::GAP: begin
                    half_cnt <= half_end ? '0 : half_cnt + 1'b1;
                    if (half_end)
                        state <= limb_link_pkg::IDLE;
                end
                default: state <= limb_link_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge i_ep50trig) begin
        if (o_ready && i_word.valid)
            shift_q <= i_word.data;
        else if (sck_fall)
            shift_q <= shift_q << 1;
    end

    assign o_pins = '{sck: sck_q, mosi: mosi_q, ssel_n: ssel_n_q};

    a_ssel_in_shift: assert property (@(posedge i_ep50trig) disable iff (i_reset_global)
        state == limb_link_pkg::SHIFT |-> !o_pins.ssel_n);

endmodule

// ==== rtl/limb_link_top.sv ====
`include "limb_defines.svh"

module limb_link_top (
    input  logic                         i_ep50trig,
    input  logic                         i_reset_global,
    input  limb_host_pkg::axil_req_t     i_axil,
    output limb_host_pkg::axil_rsp_t     o_axil,
    input  limb_link_pkg::spi_pins_t     i_spindle_pins,
    output limb_link_pkg::spi_pins_t     o_spi_pins
);

    limb_link_pkg::rate_word_t    rx_word;      // one cycle pulses, no stall
    limb_link_pkg::rate_word_t    scaled_word;
    logic                         tx_ready;
    logic [`LIMB_GAIN_W-1:0]      gain;
    logic [`LIMB_WORD_W-1:0]      last_rate;
    logic [`LIMB_WORD_W-1:0]      frames;
    logic [`LIMB_WORD_W-1:0]      drops;

    host_regs host_regs_inst (
        .i_ep50trig     (i_ep50trig),
        .i_reset_global (i_reset_global),
        .i_axil         (i_axil),
        .o_axil         (o_axil),
        .i_last_rate    (last_rate),
        .i_frames       (frames),
        .i_drops        (drops),
        .o_gain         (gain)
    );

    //////////////////////////////////////////////////////////////////////
    // rx -> scale -> tx
    //////////////////////////////////////////////////////////////////////
    spindle_rx spindle_rx_inst (
        .i_ep50trig     (i_ep50trig),
        .i_reset_global (i_reset_global),
        .i_pins         (i_spindle_pins),
        .o_word         (rx_word),
        .o_last_rate    (last_rate),
        .o_frames       (frames)
    );

    rate_scaler rate_scaler_inst (
        .i_ep50trig     (i_ep50trig),
        .i_reset_global (i_reset_global),
        .i_word         (rx_word),
        .i_gain         (gain),
        .i_ready        (tx_ready),
        .o_word         (scaled_word),
        .o_drops        (drops)
    );

    spi_tx spi_tx_inst (
        .i_ep50trig     (i_ep50trig),
        .i_reset_global (i_reset_global),
        .i_word         (scaled_word),
        .o_ready        (tx_ready),
        .o_pins         (o_spi_pins)
    );

endmodule

// ==== verification/tb_limb_link.sv ====
`include "limb_defines.svh"

module tb_limb_link;

    localparam int AXI_TIMEOUT = 50;     // cycles per AXI handshake
    localparam int OUT_TIMEOUT = 5000;   // cycles per output frame

    logic                      ep50trig;
    logic                      reset_global;
    limb_host_pkg::axil_req_t  axil_req;
    limb_host_pkg::axil_rsp_t  axil_rsp;
    limb_link_pkg::spi_pins_t  spindle_pins;
    limb_link_pkg::spi_pins_t  out_pins;

    int                        seed = 32'h17ff214a;
    logic [`LIMB_WORD_W-1:0]   out_q [$];     // words decoded from the output link
    logic [`LIMB_WORD_W-1:0]   mon_shift;
    int                        mon_bits = 0;
    logic                      sck_prev = 1'b0;
    logic                      ssel_prev = 1'b1;

    limb_link_top limb_link_top_inst (
        .i_ep50trig     (ep50trig),
        .i_reset_global (reset_global),
        .i_axil         (axil_req),
        .o_axil         (axil_rsp),
        .i_spindle_pins (spindle_pins),
        .o_spi_pins     (out_pins)
    );

    always #4 ep50trig = ~ep50trig;

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        if (actual !== expected)
            fail_run($sformatf("MISMATCH time %0t %s actual %h expected %h",
                               $time, name, actual, expected));
    endtask

    //////////////////////////////////////////////////////////////////////
    // AXI4-Lite host side
    //////////////////////////////////////////////////////////////////////
    task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                             input logic [31:0] resp);
        int cnt;
        @(posedge ep50trig);
        axil_req.aw_valid <= 1'b1;
        axil_req.aw_addr  <= addr;
        axil_req.w_valid  <= 1'b1;
        axil_req.w_data   <= data;
        axil_req.w_strb   <= '1;
        cnt = 0;
        do begin
            @(negedge ep50trig);
            cnt++;
            if (cnt > AXI_TIMEOUT)
                fail_run("timeout: write address and data were not accepted");
        end while (!axil_rsp.aw_ready);
        compare_value("w_ready", 32'(axil_rsp.w_ready), 32'd1);
        @(posedge ep50trig);
        axil_req.aw_valid <= 1'b0;
        axil_req.w_valid  <= 1'b0;
        cnt = 0;
        do begin
            @(negedge ep50trig);
            cnt++;
            if (cnt > AXI_TIMEOUT)
                fail_run("timeout: no write response");
        end while (!axil_rsp.b_valid);
        compare_value("b_resp", 32'(axil_rsp.b_resp), resp);
    endtask

    task automatic axi_read(input logic [7:0] addr, input logic [31:0] data,
                            input logic [31:0] resp);
        int cnt;
        @(posedge ep50trig);
        axil_req.ar_valid <= 1'b1;
        axil_req.ar_addr  <= addr;
        cnt = 0;
        do begin
            @(negedge ep50trig);
            cnt++;
            if (cnt > AXI_TIMEOUT)
                fail_run("timeout: read address was not accepted");
        end while (!axil_rsp.ar_ready);
        @(posedge ep50trig);
        axil_req.ar_valid <= 1'b0;
        cnt = 0;
        do begin
            @(negedge ep50trig);
            cnt++;
            if (cnt > AXI_TIMEOUT)
                fail_run("timeout: no read data");
        end while (!axil_rsp.r_valid);
        compare_value($sformatf("r_data @%h", addr), axil_rsp.r_data, data);
        compare_value("r_resp", 32'(axil_rsp.r_resp), resp);
    endtask

    //////////////////////////////////////////////////////////////////////
    // spindle input link with random phase length
    //////////////////////////////////////////////////////////////////////
    task automatic send_frame(input logic [31:0] word, input int nbits, input int max_phase);
        int phase;
        phase = 4 + (($random(seed) & 32'h7fffffff) % (max_phase - 3));
        @(posedge ep50trig);
        spindle_pins.ssel_n <= 1'b0;
        for (int i = 0; i < nbits; i++) begin
            spindle_pins.mosi <= word[31 - i];
            spindle_pins.sck  <= 1'b0;
            repeat (phase) @(posedge ep50trig);
            spindle_pins.sck  <= 1'b1;   // receiver samples here
            repeat (phase) @(posedge ep50trig);
        end
        spindle_pins.sck <= 1'b0;
        repeat (phase) @(posedge ep50trig);
        spindle_pins.ssel_n <= 1'b1;
        repeat (phase) @(posedge ep50trig);  // idle gap covering the rx latency
    endtask

    task automatic expect_output(input logic [31:0] expected);
        int cnt;
        cnt = 0;
        while (out_q.size() == 0) begin
            @(negedge ep50trig);
            cnt++;
            if (cnt > OUT_TIMEOUT)
                fail_run("timeout: no output SPI frame arrived");
        end
        compare_value("o_spi_pins word", out_q.pop_front(), expected);
    endtask

    // output link decoder
    always @(negedge ep50trig) begin
        if (!reset_global) begin
            if (!out_pins.ssel_n && out_pins.sck && !sck_prev) begin
                mon_shift = {mon_shift[`LIMB_WORD_W-2:0], out_pins.mosi};
                mon_bits  = mon_bits + 1;
            end
            if (out_pins.ssel_n && !ssel_prev) begin   // end of frame
                compare_value("output frame bit count", 32'(mon_bits), 32'd32);
                out_q.push_back(mon_shift);
                mon_bits = 0;
            end
            sck_prev  = out_pins.sck;
            ssel_prev = out_pins.ssel_n;
        end
    end

    initial begin
        int          fd;
        int          code;
        string       line;
        logic [7:0]  op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;

        ep50trig         = 1'b0;
        reset_global     = 1'b1;
        axil_req         = '0;
        axil_req.b_ready = 1'b1;   // host always takes responses
        axil_req.r_ready = 1'b1;
        spindle_pins     = '{sck: 1'b0, mosi: 1'b0, ssel_n: 1'b1};
        repeat (16) @(posedge ep50trig);
        reset_global <= 1'b0;

        @(negedge ep50trig);
        compare_value("o_spi_pins.ssel_n", 32'(out_pins.ssel_n), 32'd1);

        fd = $fopen("verification/limb_trace.txt", "r");
        if (fd == 0)
            fail_run("could not open the trace file verification/limb_trace.txt");
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 1 && line.getc(0) != "#") begin
                code = $sscanf(line, "%c %h %h %h", op, a, b, c);
                case (op)
                    "W": axi_write(a[7:0], b, c);
                    "R": axi_read(a[7:0], b, c);
                    "F": send_frame(a, int'(b), int'(c));
                    "O": expect_output(a);
                    default: fail_run($sformatf("unknown operation in trace line %s", line));
                endcase
            end
        end
        $fclose(fd);

        compare_value("unexpected output words", 32'(out_q.size()), 32'd0);
        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== verification/limb_trace.txt ====
# W addr wdata resp | R addr rdata resp | F word nbits max_phase | O word
# all fields hex, resp 0 = OKAY and 2 = SLVERR, nbits 20 = 32 bits
R 00 00000001 0
R 08 00000000 0
R 0C 00000000 0
W 00 00000003 0
R 00 00000003 0
F 00000010 20 9
O 00000030
F 80000000 20 9
O ffffffff
W 08 12345678 2
R 08 00000002 0
R 10 00000000 2
F 0000abcd 1f 9
R 08 00000002 0
R 04 80000000 0
F 00001111 20 9
O 00003333
R 08 00000003 0
R 04 00001111 0
F 00000001 20 6
F 00000002 20 6
F 00000003 20 6
O 00000003
O 00000006
R 0C 00000001 0
R 08 00000006 0

// ==== list.f ====
+incdir+rtl
rtl/limb_host_pkg.sv
rtl/limb_link_pkg.sv
rtl/host_regs.sv
rtl/spindle_rx.sv
rtl/rate_scaler.sv
rtl/spi_tx.sv
rtl/limb_link_top.sv
verification/tb_limb_link.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_limb_link -f list.f -o sim_limb_link
./obj_dir/sim_limb_link | tee sim.log
if grep -q "TEST FAIL" sim.log; then
    exit 1
fi
exit 0
